//--- src/pcie_tx_pkg.sv
// ####################
// shared types for the 64-bit PCIe TX engine
// TLP codes, FSM states, beat and request structs
// import into module bodies, scoped names in headers
// ####################

`default_nettype none

package pcie_tx_pkg;

    // fmt[1:0] and type[4:0] of the first header dword
    typedef enum logic [6:0] {
        FMT_CPLD  = 7'b10_01010, // completion with data
        FMT_CPL   = 7'b00_01010, // completion, no data
        FMT_MWR32 = 7'b10_00000  // 3DW memory write
    } fmt_type_e;

    typedef enum logic [2:0] {
        IDLE,
        CPL_HDR,     // completion dw0/dw1 on the bus
        CPL_DATA,    // dw2 plus read data
        MWR_HDR,     // write dw0/dw1
        MWR_ADDR,    // address dword plus payload dw 0
        MWR_PAYLOAD  // realigned payload beats
    } tx_state_e;

    // request fields captured from the RX side
    typedef struct packed {
        logic [2:0]  tc;
        logic        td;
        logic        ep;
        logic [1:0]  attr;
        logic [9:0]  length;
        logic [15:0] req_id;
        logic [7:0]  tag;
        logic [7:0]  be;        // {last_be, first_be}
        logic [12:0] addr;
        logic        with_data; // CplD when set
    } cpl_req_t;

    typedef struct packed {
        logic [63:0] tdata;
        logic [7:0]  tkeep;
        logic        tlast;
    } axis_beat_t;

    localparam logic [7:0] KEEP_FULL = 8'hFF;
    localparam logic [7:0] KEEP_LOW  = 8'h0F; // low dword only

    // all DMA writes go out with this tag
    localparam logic [7:0] MWR_TAG = 8'h0F;

    // largest write payload in dwords
    localparam int MAX_PAYLOAD_DW = 128;

endpackage

`default_nettype wire

//--- src/cpl_field_calc.sv
// ####################
// completion side of the TX engine
// latches a PIO read, drives the memory read port
// and builds both beats of a 1-DW Cpl/CplD
// ####################

`timescale 1ns/1ns
`default_nettype none

module cpl_field_calc (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      cpl_req,
    input  wire pcie_tx_pkg::cpl_req_t cpl_info,
    input  wire [15:0]               completer_id,
    input  wire [31:0]               rd_data,
    output logic                     cpl_pending,
    output logic [10:0]              rd_addr,
    output logic [3:0]               rd_be,
    output pcie_tx_pkg::axis_beat_t  cpl_hdr,
    output pcie_tx_pkg::axis_beat_t  cpl_data_beat,
    input  wire                      cpl_taken
);
    import pcie_tx_pkg::*;

    cpl_req_t   req_q;
    logic [3:0] first_be;
    logic [3:0] last_be;
    logic [1:0] first_off;  // disabled bytes below the first enable
    logic [1:0] first_top;  // highest enabled byte in dword 0
    logic [1:0] last_gap;   // disabled bytes above the last enable
    logic [11:0] byte_count;
    logic [6:0]  lower_addr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cpl_pending <= 1'b0;
        end else if (cpl_taken) begin
            cpl_pending <= 1'b0;
        end else if (cpl_req) begin
            cpl_pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cpl_req && !cpl_pending) begin // busy requests are dropped
            req_q <= cpl_info;
        end
    end

    assign first_be = req_q.be[3:0];
    assign last_be  = req_q.be[7:4];
    assign rd_addr  = req_q.addr[12:2];
    assign rd_be    = first_be;

    always_comb begin
        casez (first_be)
            4'b???1: first_off = 2'd0;
            4'b??10: first_off = 2'd1;
            4'b?100: first_off = 2'd2;
            4'b1000: first_off = 2'd3;
            default: first_off = 2'd0;
        endcase
        casez (first_be)
            4'b1???: first_top = 2'd3;
            4'b01??: first_top = 2'd2;
            4'b001?: first_top = 2'd1;
            default: first_top = 2'd0;
        endcase
        casez (last_be)
            4'b1???: last_gap = 2'd0;
            4'b01??: last_gap = 2'd1;
            4'b001?: last_gap = 2'd2;
            default: last_gap = 2'd3;
        endcase
    end

    // byte count per the PCIe byte-enable rules
    always_comb begin
        if (last_be != 4'b0000) begin
            byte_count = {req_q.length, 2'b00} - 12'(first_off) - 12'(last_gap);
        end else if (first_be == 4'b0000) begin
            byte_count = 12'd1; // zero-length read
        end else begin
            byte_count = 12'(first_top) - 12'(first_off) + 12'd1;
        end
    end

    assign lower_addr = req_q.with_data ? {req_q.addr[6:2], first_off} : 7'd0;

    assign cpl_hdr.tdata = {completer_id, 3'b000, 1'b0, byte_count, 1'b0,
                            (req_q.with_data ? FMT_CPLD : FMT_CPL), 1'b0, req_q.tc, 4'b0000,
                            req_q.td, req_q.ep, req_q.attr, 2'b00, req_q.length};
    assign cpl_hdr.tkeep = KEEP_FULL;
    assign cpl_hdr.tlast = 1'b0;

    // read data rides in the upper dword
    assign cpl_data_beat.tdata = {rd_data, req_q.req_id, req_q.tag, 1'b0, lower_addr};
    assign cpl_data_beat.tkeep = req_q.with_data ? KEEP_FULL : KEEP_LOW;
    assign cpl_data_beat.tlast = 1'b1;

    // the requester waits for cpl_done before the next read
    a_no_req_while_pending : assert property (@(posedge clk) disable iff (!rst_n)
        cpl_req |-> !cpl_pending);

endmodule

`default_nettype wire

//--- src/dma_dword_packer.sv
// ####################
// payload realigner for 3DW memory writes
// shifts FWFT FIFO words by one dword behind the address
// pops one word per beat taken by the FSM
// ####################

`timescale 1ns/1ns
`default_nettype none

module dma_dword_packer #(
    parameter int MAX_PAYLOAD_DW = pcie_tx_pkg::MAX_PAYLOAD_DW
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     start,
    input  wire [31:0]              dma_host_addr,
    input  wire [7:0]               dma_payload_dw,
    input  wire [63:0]              dma_data,
    input  wire                     beat_take,
    output logic                    fifo_rd_en,
    output pcie_tx_pkg::axis_beat_t pack_beat,
    output logic                    pack_last
);
    import pcie_tx_pkg::*;

    localparam int CNT_W = $clog2(MAX_PAYLOAD_DW + 1);

    logic [CNT_W-1:0] rem_q;   // dwords not yet handed out
    logic             first_q; // next beat is the address beat
    logic [31:0]      hi_q;    // upper dword of the last popped word
    logic             hi_valid;

    // address beat always carries dw 0, later beats need two dwords left
    assign hi_valid   = first_q || (rem_q >= CNT_W'(2));
    assign fifo_rd_en = beat_take && hi_valid;
    assign pack_last  = first_q ? (rem_q <= CNT_W'(1)) : (rem_q <= CNT_W'(2));

    always_comb begin
        if (first_q) begin
            pack_beat.tdata = {dma_data[31:0], dma_host_addr[31:2], 2'b00};
        end else begin
            pack_beat.tdata = {dma_data[31:0], hi_q};
        end
        pack_beat.tkeep = hi_valid ? KEEP_FULL : KEEP_LOW;
        pack_beat.tlast = pack_last;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rem_q   <= '0;
            first_q <= 1'b0;
        end else if (start) begin
            rem_q   <= CNT_W'(dma_payload_dw);
            first_q <= 1'b1;
        end else if (beat_take) begin
            first_q <= 1'b0;
            if (first_q) begin
                rem_q <= rem_q - CNT_W'(1);
            end else if (hi_valid) begin
                rem_q <= rem_q - CNT_W'(2);
            end else begin
                rem_q <= '0; // odd tail dword went out
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rd_en) begin
            hi_q <= dma_data[63:32];
        end
    end

    // DMA engine only refills for the next packet after start
    a_no_pop_after_last : assert property (@(posedge clk) disable iff (!rst_n)
        (beat_take && pack_last) |=> (!fifo_rd_en until start));

endmodule

`default_nettype wire

//--- src/tx_engine_fsm.sv
// ####################
// beat sequencer for the TX stream
// picks completion or DMA work, registers every beat
// and holds it until the core takes it
// ####################

`timescale 1ns/1ns
`default_nettype none

module tx_engine_fsm #(
    parameter int MAX_PAYLOAD_DW = pcie_tx_pkg::MAX_PAYLOAD_DW
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      cpl_pending,
    input  wire pcie_tx_pkg::axis_beat_t cpl_hdr,
    input  wire pcie_tx_pkg::axis_beat_t cpl_data_beat,
    input  wire                      dma_tlp_req,
    input  wire [7:0]                dma_payload_dw,
    input  wire [15:0]               completer_id,
    input  wire                      tx_ready,
    input  wire pcie_tx_pkg::axis_beat_t pack_beat,
    input  wire                      pack_last,
    output logic                     cpl_taken,
    output logic                     start,
    output logic                     beat_take,
    output pcie_tx_pkg::axis_beat_t  tx_beat,
    output logic                     tx_valid,
    output logic                     cpl_done,
    output logic                     dma_done
);
    import pcie_tx_pkg::*;

    localparam int CNT_W = $clog2(MAX_PAYLOAD_DW + 1);

    tx_state_e        state_q;
    axis_beat_t       mwr_hdr;
    axis_beat_t       next_beat;
    logic             load_beat;
    logic             accept;
    logic [CNT_W-1:0] mwr_len;

    assign accept  = tx_valid && tx_ready;
    assign mwr_len = dma_payload_dw[CNT_W-1:0];

    // tc, attr, td and ep all zero for DMA writes
    assign mwr_hdr.tdata = {completer_id, MWR_TAG, 4'hF, 4'hF, 1'b0, FMT_MWR32, 1'b0,
                            3'b000, 4'b0000, 1'b0, 1'b0, 2'b00, 2'b00, 10'(mwr_len)};
    assign mwr_hdr.tkeep = KEEP_FULL;
    assign mwr_hdr.tlast = 1'b0;

    // dma_done is still high the cycle the engine sees it
    assign start     = (state_q == IDLE) && !cpl_pending && dma_tlp_req && !dma_done;
    assign cpl_taken = (state_q == CPL_DATA) && accept;
    assign beat_take = accept && ((state_q == MWR_HDR) ||
                       (((state_q == MWR_ADDR) || (state_q == MWR_PAYLOAD)) && !tx_beat.tlast));

    always_comb begin
        load_beat = 1'b0;
        next_beat = cpl_hdr;
        case (state_q)
            IDLE: begin
                if (cpl_pending) begin // completion wins
                    load_beat = 1'b1;
                end else if (start) begin
                    load_beat = 1'b1;
                    next_beat = mwr_hdr;
                end
            end
            CPL_HDR: begin
                load_beat = accept;
                next_beat = cpl_data_beat;
            end
            MWR_HDR, MWR_ADDR, MWR_PAYLOAD: begin
                load_beat = beat_take;
                next_beat = '{tdata: pack_beat.tdata, tkeep: pack_beat.tkeep, tlast: pack_last};
            end
            default: load_beat = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (load_beat) begin
            tx_beat <= next_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= IDLE;
            tx_valid <= 1'b0;
            cpl_done <= 1'b0;
            dma_done <= 1'b0;
        end else begin
            cpl_done <= 1'b0;
            dma_done <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (cpl_pending) begin
                        tx_valid <= 1'b1;
                        state_q  <= CPL_HDR;
                    end else if (start) begin
                        tx_valid <= 1'b1;
                        state_q  <= MWR_HDR;
                    end
                end
                CPL_HDR: if (accept) state_q <= CPL_DATA;
                CPL_DATA: begin
                    if (accept) begin
                        tx_valid <= 1'b0;
                        cpl_done <= 1'b1;
                        state_q  <= IDLE;
                    end
                end
                MWR_HDR: if (accept) state_q <= MWR_ADDR;
                MWR_ADDR, MWR_PAYLOAD: begin
                    if (accept && tx_beat.tlast) begin
                        tx_valid <= 1'b0;
                        dma_done <= 1'b1;
                        state_q  <= IDLE;
                    end else if (accept) begin
                        state_q <= MWR_PAYLOAD;
                    end
                end
                default: begin
                    tx_valid <= 1'b0;
                    state_q  <= IDLE;
                end
            endcase
        end
    end

    // AXI-Stream rule toward the PCIe core
    a_hold_under_stall : assert property (@(posedge clk) disable iff (!rst_n)
        (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_beat)));

endmodule

`default_nettype wire

//--- src/pcie_tx_engine.sv
// ####################
// PCIe endpoint TX engine, 64-bit AXI-Stream
// PIO completions and DMA memory writes
// ####################

`timescale 1ns/1ns
`default_nettype none

module pcie_tx_engine #(
    parameter int MAX_PAYLOAD_DW = pcie_tx_pkg::MAX_PAYLOAD_DW
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        cpl_req,
    input  wire pcie_tx_pkg::cpl_req_t cpl_info,
    input  wire [15:0]                 completer_id,
    output logic                       cpl_done,
    output logic [10:0]                rd_addr,
    output logic [3:0]                 rd_be,
    input  wire [31:0]                 rd_data,
    output pcie_tx_pkg::axis_beat_t    tx_beat,
    output logic                       tx_valid,
    input  wire                        tx_ready,
    input  wire                        dma_tlp_req,
    input  wire [31:0]                 dma_host_addr,
    input  wire [7:0]                  dma_payload_dw,
    input  wire [63:0]                 dma_data,
    output logic                       fifo_rd_en,
    output logic                       dma_done
);
    import pcie_tx_pkg::*;

    logic       cpl_pending;
    logic       cpl_taken;
    logic       start;
    logic       beat_take;
    logic       pack_last;
    axis_beat_t cpl_hdr;
    axis_beat_t cpl_data_beat;
    axis_beat_t pack_beat;

    cpl_field_calc u_cpl_calc (
        .clk, .rst_n, .cpl_req, .cpl_info, .completer_id, .rd_data,
        .cpl_pending, .rd_addr, .rd_be, .cpl_hdr, .cpl_data_beat, .cpl_taken
    );

    dma_dword_packer #(.MAX_PAYLOAD_DW(MAX_PAYLOAD_DW)) u_packer (
        .clk, .rst_n, .start, .dma_host_addr, .dma_payload_dw, .dma_data,
        .beat_take, .fifo_rd_en, .pack_beat, .pack_last
    );

    tx_engine_fsm #(.MAX_PAYLOAD_DW(MAX_PAYLOAD_DW)) u_fsm (
        .clk, .rst_n, .cpl_pending, .cpl_hdr, .cpl_data_beat, .dma_tlp_req,
        .dma_payload_dw, .completer_id, .tx_ready, .pack_beat, .pack_last,
        .cpl_taken, .start, .beat_take, .tx_beat, .tx_valid, .cpl_done, .dma_done
    );

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
// ####################
// clock and reset source for the TX engine testbench
// 4 ns clock, reset held low for a few cycles
// ####################

`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1; // released on an edge like any other input
    end

endmodule

`default_nettype wire

//--- verif/pcie_tx_checker.sv
// ####################
// stream checker for the TX engine testbench
// compares accepted beats with the expected queue
// watches stalls, done pulses and FIFO pops
// ####################

`timescale 1ns/1ns
`default_nettype none

module pcie_tx_checker (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire pcie_tx_pkg::axis_beat_t tx_beat,
    input  wire                     tx_valid,
    input  wire                     tx_ready,
    input  wire                     cpl_done,
    input  wire                     dma_done,
    input  wire                     fifo_rd_en,
    output int                      err_count,
    output int                      beat_count
);
    import pcie_tx_pkg::*;

    axis_beat_t exp_q [$];
    logic       kind_q [$];  // set for DMA beats
    int         pops_q [$];
    int         pop_cnt;
    logic       done_due;    // last beat went out one cycle ago
    logic       done_kind;
    logic       stalled;
    logic       in_reset;
    axis_beat_t held_beat;

    initial begin
        err_count  = 0;
        beat_count = 0;
        pop_cnt    = 0;
        done_due   = 1'b0;
        stalled    = 1'b0;
        in_reset   = 1'b1;
    end

    task automatic expect_beat(input axis_beat_t beat, input logic is_dma);
        exp_q.push_back(beat);
        kind_q.push_back(is_dma);
    endtask

    task automatic expect_pops(input int n);
        pops_q.push_back(n);
    endtask

    function automatic int pending_beats();
        return exp_q.size();
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] got);
        $display("FAIL %0t ns %s exp %0h got %0h", $time, name, exp, got);
        err_count++;
    endtask

    task automatic check_done();
        int exp_pops;
        if (done_due) begin
            done_due = 1'b0;
            if (cpl_done !== !done_kind) report_mismatch("cpl_done", !done_kind, cpl_done);
            if (dma_done !== done_kind) report_mismatch("dma_done", done_kind, dma_done);
            if (done_kind && pops_q.size() > 0) begin
                exp_pops = pops_q.pop_front();
                if (pop_cnt != exp_pops) report_mismatch("fifo_rd_en count", exp_pops, pop_cnt);
                pop_cnt = 0;
            end
        end else if (cpl_done !== 1'b0 || dma_done !== 1'b0) begin
            $display("ERROR %0t ns: done pulse without a finished packet", $time);
            err_count++;
        end
    endtask

    task automatic compare_beat(input axis_beat_t got);
        axis_beat_t  exp;
        logic        kind;
        logic [63:0] mask;
        int          b;
        if (exp_q.size() == 0) begin
            $display("ERROR %0t ns: beat accepted while no packet was expected", $time);
            err_count++;
            return;
        end
        exp  = exp_q.pop_front();
        kind = kind_q.pop_front();
        for (b = 0; b < 8; b++) begin
            mask[8 * b +: 8] = {8{exp.tkeep[b]}}; // dead bytes are don't care
        end
        if (got.tkeep !== exp.tkeep) report_mismatch("tx_beat.tkeep", exp.tkeep, got.tkeep);
        if (got.tlast !== exp.tlast) report_mismatch("tx_beat.tlast", exp.tlast, got.tlast);
        if ((got.tdata & mask) !== (exp.tdata & mask)) begin
            report_mismatch("tx_beat.tdata", exp.tdata, got.tdata);
        end
        if (exp.tlast) begin
            done_due  = 1'b1;
            done_kind = kind;
        end
        beat_count++;
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            in_reset = 1'b1;
            stalled  = 1'b0;
        end else begin
            if (in_reset) begin
                in_reset = 1'b0;
                if ({tx_valid, cpl_done, dma_done, fifo_rd_en} !== 4'b0000) begin
                    $display("ERROR %0t ns: outputs not idle after reset", $time);
                    err_count++;
                end
            end
            check_done();
            // beat must sit still until the core takes it
            if (stalled && tx_valid !== 1'b1) begin
                $display("ERROR %0t ns: tx_valid dropped under back-pressure", $time);
                err_count++;
            end else if (stalled && tx_beat !== held_beat) begin
                report_mismatch("tx_beat.tdata under stall", held_beat.tdata, tx_beat.tdata);
            end
            if (fifo_rd_en === 1'b1) begin
                pop_cnt++;
                if (!(tx_valid === 1'b1 && tx_ready === 1'b1)) begin
                    $display("ERROR %0t ns: FIFO popped while no beat was accepted", $time);
                    err_count++;
                end
            end
            if (tx_valid === 1'b1 && tx_ready === 1'b1) compare_beat(tx_beat);
            stalled   = (tx_valid === 1'b1) && (tx_ready !== 1'b1);
            held_beat = tx_beat;
        end
    end

endmodule

`default_nettype wire

//--- verif/pcie_tx_tb.sv
// ####################
// testbench top for the PCIe TX engine
// reads verif/pcie_tx_vectors.txt, drives completions and DMA writes
// models the read memory, the FWFT FIFO and a stalling core
// ####################

`timescale 1ns/1ns
`default_nettype none

module pcie_tx_tb;
    import pcie_tx_pkg::*;

    localparam int          MAX_VEC      = 32;
    localparam logic [15:0] COMPLETER_ID = 16'h0100;
    localparam logic [31:0] LCG_SEED     = 32'h6e5e_328a;
    localparam string       VEC_FILE     = "verif/pcie_tx_vectors.txt";

    logic        clk;
    logic        rst_n;
    logic        cpl_req;
    cpl_req_t    cpl_info;
    logic [15:0] completer_id;
    logic        cpl_done;
    logic [10:0] rd_addr;
    logic [3:0]  rd_be;
    logic [31:0] rd_data;
    axis_beat_t  tx_beat;
    logic        tx_valid;
    logic        tx_ready;
    logic        dma_tlp_req;
    logic [31:0] dma_host_addr;
    logic [7:0]  dma_payload_dw;
    logic [63:0] dma_data;
    logic        fifo_rd_en;
    logic        dma_done;
    int          err_count;
    int          beat_count;

    byte         vec_kind [MAX_VEC];
    cpl_req_t    vec_req  [MAX_VEC];
    logic [11:0] vec_bc   [MAX_VEC];
    logic [6:0]  vec_la   [MAX_VEC];
    logic [31:0] vec_addr [MAX_VEC];
    int          vec_ndw  [MAX_VEC];
    int          vec_count;
    int          word_idx;
    logic [31:0] lcg_state;
    logic        timed_out;
    logic        file_error;

    tb_clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(4)) clk_gen (.clk, .rst_n);

    pcie_tx_engine #(.MAX_PAYLOAD_DW(MAX_PAYLOAD_DW)) uut (
        .clk, .rst_n, .cpl_req, .cpl_info, .completer_id, .cpl_done, .rd_addr, .rd_be,
        .rd_data, .tx_beat, .tx_valid, .tx_ready, .dma_tlp_req, .dma_host_addr,
        .dma_payload_dw, .dma_data, .fifo_rd_en, .dma_done
    );

    pcie_tx_checker chk (
        .clk, .rst_n, .tx_beat, .tx_valid, .tx_ready, .cpl_done, .dma_done, .fifo_rd_en,
        .err_count, .beat_count
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // payload dword i as the FIFO holds it
    function automatic logic [31:0] payload_dw(input int i);
        return 32'h1000_0000 + 32'(i);
    endfunction

    // rd_be rides just above the word address
    always @(posedge clk) begin
        rd_data <= {8'hA5, 9'h000, rd_be, rd_addr}; // one cycle behind the address
    end

    // FWFT FIFO, rewound to word 0 after each write packet
    always @(posedge clk) begin
        if (!rst_n || dma_done) begin
            word_idx <= 0;
            dma_data <= {payload_dw(1), payload_dw(0)};
        end else if (fifo_rd_en) begin
            word_idx <= word_idx + 1;
            dma_data <= {payload_dw(2 * word_idx + 3), payload_dw(2 * word_idx + 2)};
        end
    end

    always @(posedge clk) begin
        lcg_state <= lcg_next(lcg_state);
        tx_ready  <= (lcg_state[31:30] != 2'b00); // about one stall in four
    end

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        byte         kind;
        int unsigned f [12];
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("ERROR: cannot open vector file %s", VEC_FILE);
            file_error = 1'b1;
            return;
        end
        while (!$feof(fd) && vec_count < MAX_VEC) begin
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line.getc(0) == "#") continue;
            kind = line.getc(0);
            if (kind == "C") begin
                n = $sscanf(line, "C %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                            f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
            end else begin
                n = $sscanf(line, "D %h %d", f[0], f[1]);
            end
            if ((kind == "C" && n != 12) || (kind != "C" && n != 2)) begin
                $display("ERROR: malformed vector line: %s", line);
                file_error = 1'b1;
                continue;
            end
            vec_kind[vec_count] = kind;
            vec_req[vec_count]  = {f[0][2:0], f[1][0], f[2][0], f[3][1:0], f[4][9:0],
                                   f[5][15:0], f[6][7:0], f[7][7:0], f[8][12:0], f[9][0]};
            vec_bc[vec_count]   = f[10][11:0];
            vec_la[vec_count]   = f[11][6:0];
            vec_addr[vec_count] = f[0];
            vec_ndw[vec_count]  = int'(f[1]);
            vec_count++;
        end
        $fclose(fd);
    endtask

    task automatic queue_completion(input int i);
        cpl_req_t    r;
        axis_beat_t  b;
        logic [31:0] dw0;
        logic [31:0] dw1;
        r   = vec_req[i];
        dw0 = {1'b0, (r.with_data ? 7'b10_01010 : 7'b00_01010), 1'b0, r.tc, 4'h0,
               r.td, r.ep, r.attr, 2'b00, r.length};
        dw1 = {COMPLETER_ID, 3'b000, 1'b0, vec_bc[i]};
        b.tdata = {dw1, dw0};
        b.tkeep = 8'hFF;
        b.tlast = 1'b0;
        chk.expect_beat(b, 1'b0);
        b.tdata = {8'hA5, 9'h000, r.be[3:0], r.addr[12:2], r.req_id, r.tag, 1'b0, vec_la[i]};
        b.tkeep = r.with_data ? 8'hFF : 8'h0F; // Cpl has no data dword
        b.tlast = 1'b1;
        chk.expect_beat(b, 1'b0);
    endtask

    task automatic queue_mwr(input int i);
        int         n;
        int         beats;
        int         j;
        axis_beat_t b;
        n     = vec_ndw[i];
        beats = 1 + (n + 2) / 2;
        b.tdata = {COMPLETER_ID, 8'h0F, 4'hF, 4'hF, 1'b0, 7'b10_00000, 1'b0, 3'b000, 4'h0,
                   2'b00, 2'b00, 2'b00, 10'(n)};
        b.tkeep = 8'hFF;
        b.tlast = 1'b0;
        chk.expect_beat(b, 1'b1);
        for (j = 1; j < beats; j++) begin
            if (j == 1) begin
                b.tdata = {payload_dw(0), vec_addr[i][31:2], 2'b00};
            end else begin
                b.tdata = {payload_dw(2 * j - 2), payload_dw(2 * j - 3)};
            end
            b.tlast = (j == beats - 1);
            b.tkeep = (b.tlast && (n % 2 == 0)) ? 8'h0F : 8'hFF;
            chk.expect_beat(b, 1'b1);
        end
        chk.expect_pops((n + 1) / 2);
    endtask

    task automatic pulse_completion(input int i);
        @(posedge clk);
        cpl_req  <= 1'b1;
        cpl_info <= vec_req[i];
        @(posedge clk);
        cpl_req  <= 1'b0;
    endtask

    task automatic raise_dma(input int i);
        dma_tlp_req    <= 1'b1;
        dma_host_addr  <= vec_addr[i];
        dma_payload_dw <= 8'(vec_ndw[i]);
    endtask

    task automatic wait_cpl_done();
        do begin
            @(posedge clk);
        end while (cpl_done !== 1'b1);
    endtask

    task automatic wait_dma_done();
        do begin
            @(posedge clk);
        end while (dma_done !== 1'b1);
        dma_tlp_req <= 1'b0;
    endtask

    task automatic run_vectors();
        int i;
        i = 0;
        while (i < vec_count) begin
            if (vec_kind[i] == "D" && i + 1 < vec_count && vec_kind[i + 1] == "C") begin
                // completion latched first, then both wait together in IDLE
                queue_completion(i + 1);
                queue_mwr(i);
                pulse_completion(i + 1);
                raise_dma(i);
                fork
                    wait_cpl_done();
                    wait_dma_done();
                join
                i += 2;
            end else if (vec_kind[i] == "C") begin
                queue_completion(i);
                pulse_completion(i);
                wait_cpl_done();
                i++;
            end else begin
                queue_mwr(i);
                @(posedge clk);
                raise_dma(i);
                wait_dma_done();
                i++;
            end
        end
    endtask

    initial begin
        int limit;
        int max_beats;
        int total;
        int i;
        cpl_req        <= 1'b0;
        cpl_info       <= '0;
        completer_id   <= COMPLETER_ID;
        rd_data        <= '0;
        tx_ready       <= 1'b1;
        dma_tlp_req    <= 1'b0;
        dma_host_addr  <= '0;
        dma_payload_dw <= '0;
        dma_data       <= '0;
        lcg_state      <= LCG_SEED;
        timed_out  = 1'b0;
        file_error = 1'b0;
        vec_count  = 0;
        load_vectors();
        max_beats = 2;
        for (i = 0; i < vec_count; i++) begin
            if (vec_kind[i] == "D" && 1 + (vec_ndw[i] + 2) / 2 > max_beats) begin
                max_beats = 1 + (vec_ndw[i] + 2) / 2;
            end
        end
        limit = vec_count * max_beats * 8;
        wait (rst_n === 1'b1);
        repeat (8) @(posedge clk); // quiet bus expected here
        if (!file_error) begin
            fork
                run_vectors();
                begin
                    repeat (limit) @(posedge clk);
                    timed_out = 1'b1;
                end
            join_any
            disable fork;
        end
        repeat (4) @(posedge clk);
        if (timed_out) begin
            $display("ERROR: watchdog expired after %0d cycles, a packet never finished", limit);
        end
        total = err_count + int'(timed_out) + int'(file_error);
        if (chk.pending_beats() != 0) begin
            $display("ERROR: %0d expected beats were never sent", chk.pending_beats());
            total++;
        end
        $display("checks done: %0d vectors, %0d beats compared, %0d errors",
                 vec_count, beat_count, total);
        if (total == 0 && vec_count > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/pcie_tx_vectors.txt
# C tc td ep attr length req_id tag be addr with_data exp_byte_count exp_lower_addr (all hex)
# D host_addr (hex) payload_dwords (decimal); a D right before a C is issued together with it
C 0 0 0 0 001 1234 01 0F 0100 1 004 00
C 2 0 0 1 001 ABCD 22 06 0A44 1 002 45
D 80000000 1
D 1234567B 2
C 1 0 0 0 001 0042 33 08 0FFC 0 001 00
D FFFF0004 3
C 7 1 1 3 001 5A5A 44 0C 1FFC 1 002 7E
D 00001000 128
C 0 0 0 2 002 0007 55 3C 0208 1 004 0A
D 40000010 7
C 3 0 0 0 001 00FE 66 00 0010 1 001 10
D 20000020 16

//--- compile.f
src/pcie_tx_pkg.sv
src/cpl_field_calc.sv
src/dma_dword_packer.sv
src/tx_engine_fsm.sv
src/pcie_tx_engine.sv
verif/tb_clock_gen.sv
verif/pcie_tx_checker.sv
verif/pcie_tx_tb.sv

//--- Bender.yml
package:
  name: pcie_tx_engine

sources:
  - files:
      - src/pcie_tx_pkg.sv
      - src/cpl_field_calc.sv
      - src/dma_dword_packer.sv
      - src/tx_engine_fsm.sv
      - src/pcie_tx_engine.sv
  - target: simulation
    files:
      - verif/tb_clock_gen.sv
      - verif/pcie_tx_checker.sv
      - verif/pcie_tx_tb.sv
